// File: source/rs_pkg.sv
/*
 * shared types, code constants and decoder states for the RS(31) receiver,
 * plus GF(32) multiply helpers.
 */
`default_nettype none

package rs_pkg;

    typedef logic [4:0] gf_symbol_t;
    typedef logic [1:0] wb_addr_t;
    typedef logic [7:0] wb_data_t;

    localparam int CODE_LEN = 31;
    localparam int POS_WIDTH = 5;
    // x^5 = x^2 + 1.
    localparam gf_symbol_t FIELD_POLY = 5'b00101;

    typedef enum logic {
        COLLECT,
        DELIVER
    } decoder_state_t;

    function automatic gf_symbol_t gf_mul_alpha(input gf_symbol_t a);
        return {a[3:0], 1'b0} ^ (a[4] ? FIELD_POLY : gf_symbol_t'(0));
    endfunction

    // divide by x, folding the reduction back in when bit 0 is set.
    function automatic gf_symbol_t gf_mul_alpha_inv(input gf_symbol_t a);
        logic [5:0] t;
        t = {1'b0, a} ^ (a[0] ? {1'b1, FIELD_POLY} : 6'd0);
        return t[5:1];
    endfunction

    function automatic gf_symbol_t gf_mul(input gf_symbol_t a, input gf_symbol_t b);
        gf_symbol_t acc;
        gf_symbol_t p;
        acc = '0;
        p = a;
        for (int i = 0; i < 5; i++)
        begin
            if (b[i])
                acc = acc ^ p;
            p = gf_mul_alpha(p);
        end
        return acc;
    endfunction

    // meant for constant exponents only.
    function automatic gf_symbol_t gf_alpha_pow(input int n);
        gf_symbol_t r;
        r = 5'b00001;
        for (int i = 0; i < n; i++)
        begin
            r = gf_mul_alpha(r);
        end
        return r;
    endfunction

endpackage

`default_nettype wire

// File: source/fifo_register.sv
/*
 * received-word buffer, a 31-stage symbol shift chain.
 * zero fill at the head while the word is read out.
 */
`timescale 1ns/1ps
`default_nettype none

module fifo_register (
    input  wire                 clock,
    input  wire                 rst_n,
    input  wire                 shift_fifo,
    input  wire                 en_infifo,
    input  wire rs_pkg::gf_symbol_t datain,
    output rs_pkg::gf_symbol_t  dataout
);

    import rs_pkg::*;

    gf_symbol_t stage [CODE_LEN];
    gf_symbol_t head_in;

    // head takes the bus symbol on writes, zero during read-out.
    always_comb
    begin
        if (en_infifo)
            head_in = datain;
        else
            head_in = '0;
    end

    // whole chain moves one place per shift, holds otherwise.
    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < CODE_LEN; i++)
                stage[i] <= '0;
        end
        else if (shift_fifo)
        begin
            stage[0] <= head_in;
            for (int i = 1; i < CODE_LEN; i++)
                stage[i] <= stage[i-1];
        end
    end

    // oldest symbol, highest degree first.
    assign dataout = stage[CODE_LEN-1];

endmodule

`default_nettype wire

// File: source/syndrome_calc.sv
/*
 * syndrome accumulator, S1 = r(alpha) and S2 = r(alpha^2) by Horner's rule.
 */
`timescale 1ns/1ps
`default_nettype none

module syndrome_calc (
    input  wire                 clock,
    input  wire                 rst_n,
    input  wire                 accept,
    input  wire                 syn_clear,
    input  wire rs_pkg::gf_symbol_t symbol,
    output rs_pkg::gf_symbol_t  s1,
    output rs_pkg::gf_symbol_t  s2
);

    import rs_pkg::*;

    gf_symbol_t s1_next;
    gf_symbol_t s2_next;

    // one Horner step per symbol.
    // symbols arrive highest degree first, so the
    // running sum is scaled before the new term is added.
    always_comb
    begin
        s1_next = gf_mul_alpha(s1) ^ symbol;
        s2_next = gf_mul_alpha(gf_mul_alpha(s2)) ^ symbol;
    end

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            s1 <= '0;
            s2 <= '0;
        end
        else if (syn_clear)
        begin
            // ready for the next word.
            s1 <= '0;
            s2 <= '0;
        end
        else if (accept)
        begin
            s1 <= s1_next;
            s2 <= s2_next;
        end
    end

endmodule

`default_nettype wire

// File: source/chien_corrector.sv
/*
 * single-error search over positions 30 down to 0.
 * corrects the buffer tail on the fly and keeps the decode flags.
 */
`timescale 1ns/1ps
`default_nettype none

module chien_corrector (
    input  wire                 clock,
    input  wire                 rst_n,
    input  wire                 syn_load,
    input  wire rs_pkg::gf_symbol_t s1,
    input  wire rs_pkg::gf_symbol_t s2,
    input  wire                 step,
    input  wire rs_pkg::gf_symbol_t symbol_in,
    output rs_pkg::gf_symbol_t  symbol_out,
    output logic                corrected,
    output logic                uncorrectable
);

    import rs_pkg::*;

    gf_symbol_t           loc;
    gf_symbol_t           mag;
    gf_symbol_t           s2_q;
    logic                 s1_nz;
    logic [POS_WIDTH-1:0] pos;
    logic                 hit;
    logic                 syn_nz;
    logic                 last_step;

    // error at j gives S1*alpha^j == S2.
    assign hit = s1_nz && (loc == s2_q);
    assign syn_nz = s1_nz || (s2_q != '0);
    assign last_step = step && (pos == '0);

    assign symbol_out = hit ? (symbol_in ^ mag) : symbol_in;

    // locator starts at S1*alpha^30, magnitude at S1*alpha^-30.
    always_ff @(posedge clock)
    begin
        if (syn_load)
        begin
            loc  <= gf_mul(s1, gf_alpha_pow(CODE_LEN - 1));
            mag  <= gf_mul_alpha(s1);
            s2_q <= s2;
        end
        else if (step)
        begin
            loc <= gf_mul_alpha_inv(loc);
            mag <= gf_mul_alpha(mag);
        end
    end

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            s1_nz         <= 1'b0;
            pos           <= '0;
            corrected     <= 1'b0;
            uncorrectable <= 1'b0;
        end
        else if (syn_load)
        begin
            s1_nz         <= (s1 != '0);
            pos           <= POS_WIDTH'(CODE_LEN - 1);
            corrected     <= 1'b0;
            uncorrectable <= 1'b0;
        end
        else if (step)
        begin
            pos <= pos - 1'b1;
            if (hit)
                corrected <= 1'b1;
            // nonzero syndromes but nothing matched over the whole word.
            if (last_step && syn_nz && !corrected && !hit)
                uncorrectable <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/rs_wb_slave.sv
/*
 * Wishbone classic slave with the collect/deliver FSM,
 * symbol counter and decoder control pulses.
 */
`timescale 1ns/1ps
`default_nettype none

module rs_wb_slave (
    input  wire                 clock,
    input  wire                 rst_n,
    input  wire                 cyc,
    input  wire                 stb,
    input  wire                 we,
    input  wire rs_pkg::wb_addr_t   adr,
    input  wire rs_pkg::wb_data_t   dat_w,
    output rs_pkg::wb_data_t    dat_r,
    output logic                ack,
    output logic                accept,
    output logic                shift_fifo,
    output logic                en_infifo,
    output logic                syn_clear,
    output logic                syn_load,
    output logic                step,
    output rs_pkg::gf_symbol_t  symbol,
    input  wire rs_pkg::gf_symbol_t corr_symbol,
    input  wire                 corrected,
    input  wire                 uncorrectable
);

    import rs_pkg::*;

    decoder_state_t       state;
    logic [POS_WIDTH-1:0] pos;
    logic                 req;
    logic                 data_acc;
    logic                 last_pos;
    wb_data_t             rd_data;

    // new request, high only in the cycle before ack.
    assign req = cyc && stb && !ack;
    // address 0 is the symbol port.
    assign data_acc = req && (adr == 2'd0);
    assign last_pos = (pos == POS_WIDTH'(CODE_LEN - 1));

    assign accept     = data_acc && we && (state == COLLECT);
    assign step       = data_acc && !we && (state == DELIVER);
    assign shift_fifo = accept || step;
    assign en_infifo  = accept;
    assign syn_clear  = step && last_pos;
    assign symbol     = dat_w[4:0];

    // read mux, status lives at address 1.
    always_comb
    begin
        rd_data = '0;
        if (!we)
        begin
            case (adr)
                2'd0:
                begin
                    if (state == DELIVER)
                        rd_data = wb_data_t'(corr_symbol);
                end
                2'd1: rd_data = wb_data_t'({uncorrectable, corrected, state == DELIVER});
                default: rd_data = '0;
            endcase
        end
    end

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= COLLECT;
            pos      <= '0;
            syn_load <= 1'b0;
        end
        else
        begin
            // syndromes hold the last symbol one cycle after its accept.
            syn_load <= accept && last_pos;
            if (shift_fifo)
            begin
                if (last_pos)
                begin
                    pos   <= '0;
                    state <= (state == COLLECT) ? DELIVER : COLLECT;
                end
                else
                    pos <= pos + 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ack   <= 1'b0;
            dat_r <= '0;
        end
        else
        begin
            ack <= req;
            if (req)
                dat_r <= rd_data;
        end
    end

endmodule

`default_nettype wire

// File: source/rs_decoder_top.sv
/*
 * RS(31) single-error receive subsystem, top level.
 */
`timescale 1ns/1ps
`default_nettype none

module rs_decoder_top (
    input  wire                 clock,
    input  wire                 rst_n,
    input  wire                 cyc,
    input  wire                 stb,
    input  wire                 we,
    input  wire rs_pkg::wb_addr_t   adr,
    input  wire rs_pkg::wb_data_t   dat_w,
    output rs_pkg::wb_data_t    dat_r,
    output logic                ack
);

    import rs_pkg::*;

    logic       accept;
    logic       shift_fifo;
    logic       en_infifo;
    logic       syn_clear;
    logic       syn_load;
    logic       step;
    logic       corrected;
    logic       uncorrectable;
    gf_symbol_t wr_symbol;
    gf_symbol_t fifo_tail;
    gf_symbol_t corr_symbol;
    gf_symbol_t s1;
    gf_symbol_t s2;

    rs_wb_slave u_slave (
        .clock         (clock),
        .rst_n         (rst_n),
        .cyc           (cyc),
        .stb           (stb),
        .we            (we),
        .adr           (adr),
        .dat_w         (dat_w),
        .dat_r         (dat_r),
        .ack           (ack),
        .accept        (accept),
        .shift_fifo    (shift_fifo),
        .en_infifo     (en_infifo),
        .syn_clear     (syn_clear),
        .syn_load      (syn_load),
        .step          (step),
        .symbol        (wr_symbol),
        .corr_symbol   (corr_symbol),
        .corrected     (corrected),
        .uncorrectable (uncorrectable)
    );

    fifo_register u_fifo (
        .clock      (clock),
        .rst_n      (rst_n),
        .shift_fifo (shift_fifo),
        .en_infifo  (en_infifo),
        .datain     (wr_symbol),
        .dataout    (fifo_tail)
    );

    syndrome_calc u_syndrome (
        .clock     (clock),
        .rst_n     (rst_n),
        .accept    (accept),
        .syn_clear (syn_clear),
        .symbol    (wr_symbol),
        .s1        (s1),
        .s2        (s2)
    );

    chien_corrector u_chien (
        .clock         (clock),
        .rst_n         (rst_n),
        .syn_load      (syn_load),
        .s1            (s1),
        .s2            (s2),
        .step          (step),
        .symbol_in     (fifo_tail),
        .symbol_out    (corr_symbol),
        .corrected     (corrected),
        .uncorrectable (uncorrectable)
    );

endmodule

`default_nettype wire

// File: testbench/rs_checker.sv
/*
 * Wishbone monitor for the RS decoder testbench.
 * compares each read with the expected value given with its request.
 */
`timescale 1ns/1ps
`default_nettype none

module rs_checker (
    input  wire                   clock,
    input  wire                   rst_n,
    input  wire                   cyc,
    input  wire                   stb,
    input  wire                   we,
    input  wire rs_pkg::wb_addr_t adr,
    input  wire rs_pkg::wb_data_t dat_r,
    input  wire                   ack,
    input  wire rs_pkg::wb_data_t exp_data,
    output int                    check_count,
    output int                    error_count
);

    import rs_pkg::*;

    logic     pending;
    logic     pending_rd;
    wb_addr_t pending_adr;
    wb_data_t pending_exp;

    // request captured in its first cycle, data checked in the ack cycle.
    always @(negedge clock)
    begin
        if (!rst_n)
        begin
            pending     = 1'b0;
            pending_rd  = 1'b0;
            pending_adr = '0;
            pending_exp = '0;
            check_count = 0;
            error_count = 0;
        end
        else if (ack)
        begin
            // a second ack cycle lands here with nothing pending.
            if (!pending)
            begin
                error_count++;
                $display("ack seen at %0d ns without an outstanding request", $time);
            end
            else if (pending_rd)
            begin
                check_count++;
                if (dat_r !== pending_exp)
                begin
                    error_count++;
                    $display("Fail at %0d ns: read of adr %0d returned %02h, expected %02h",
                             $time, pending_adr, dat_r, pending_exp);
                end
            end
            pending = 1'b0;
        end
        else if (cyc && stb)
        begin
            pending     = 1'b1;
            pending_rd  = !we;
            pending_adr = adr;
            pending_exp = exp_data;
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_rs_decoder.sv
/*
 * testbench for the RS(31) receiver: bus driver tasks, LCG stimulus,
 * reference encoder and single-error decoder.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_rs_decoder;

    import rs_pkg::*;

    typedef logic [CODE_LEN*5-1:0] word_t;
    typedef logic [(CODE_LEN-2)*5-1:0] msg_t;

    localparam int ACK_TIMEOUT = 20;

    logic        clock;
    logic        rst_n;
    logic        cyc;
    logic        stb;
    logic        we;
    wb_addr_t    adr;
    wb_data_t    dat_w;
    wb_data_t    dat_r;
    logic        ack;
    wb_data_t    exp_data;
    int          check_count;
    int          error_count;
    logic [31:0] rand_state;
    gf_symbol_t  exp_tab [31];
    int          log_tab [32];

    rs_decoder_top dut (
        .clock (clock),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    rs_checker u_checker (
        .clock       (clock),
        .rst_n       (rst_n),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .dat_r       (dat_r),
        .ack         (ack),
        .exp_data    (exp_data),
        .check_count (check_count),
        .error_count (error_count)
    );

    always #20 clock = ~clock;

    // power and log tables from x^5 = x^2 + 1.
    task automatic build_tables();
        logic [5:0] x;
        x = 6'd1;
        log_tab[0] = 0;
        for (int i = 0; i < 31; i++)
        begin
            exp_tab[i] = x[4:0];
            log_tab[x[4:0]] = i;
            x = x << 1;
            if (x[5])
                x = x ^ 6'b100101;
        end
    endtask

    function automatic gf_symbol_t ref_pow(input int n);
        return exp_tab[n % 31];
    endfunction

    function automatic gf_symbol_t ref_mul(input gf_symbol_t a, input gf_symbol_t b);
        if (a == '0 || b == '0)
            return '0;
        return ref_pow(log_tab[a] + log_tab[b]);
    endfunction

    function automatic int rand_below(input int n);
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return int'(rand_state[30:8]) % n;
    endfunction

    // systematic RS(31,29), g(x) = (x - a)(x - a^2), parity in positions 1 and 0.
    function automatic word_t encode_word(input msg_t msg);
        gf_symbol_t fb;
        gf_symbol_t r1;
        gf_symbol_t r0;
        gf_symbol_t g1;
        gf_symbol_t g0;
        g1 = ref_pow(1) ^ ref_pow(2);
        g0 = ref_pow(3);
        r1 = '0;
        r0 = '0;
        for (int i = CODE_LEN - 3; i >= 0; i--)
        begin
            fb = msg[5*i +: 5] ^ r1;
            r1 = r0 ^ ref_mul(fb, g1);
            r0 = ref_mul(fb, g0);
        end
        return {msg, r1, r0};
    endfunction

    // single error at j when S1*a^j == S2, magnitude S1*a^-j.
    function automatic void decode_ref(input word_t w, output word_t fixed,
                                       output logic corr, output logic unc);
        gf_symbol_t s1;
        gf_symbol_t s2;
        gf_symbol_t sym;
        s1 = '0;
        s2 = '0;
        for (int j = 0; j < CODE_LEN; j++)
        begin
            sym = w[5*j +: 5];
            s1 = s1 ^ ref_mul(sym, ref_pow(j));
            s2 = s2 ^ ref_mul(sym, ref_pow(2 * j));
        end
        fixed = w;
        corr = 1'b0;
        for (int j = 0; j < CODE_LEN; j++)
        begin
            if (s1 != '0 && ref_mul(s1, ref_pow(j)) == s2)
            begin
                fixed[5*j +: 5] = fixed[5*j +: 5] ^ ref_mul(s1, ref_pow(CODE_LEN - j));
                corr = 1'b1;
            end
        end
        unc = (s1 != '0 || s2 != '0) && !corr;
    endfunction

    task automatic end_run(input logic timed_out);
        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timed_out);
        if (timed_out || error_count != 0)
            $display("Errors found");
        else
            $display("No errors");
        $finish;
    endtask

    // one classic cycle, request held until ack.
    task automatic bus_cycle(input logic write, input wb_addr_t a, input wb_data_t d,
                             input wb_data_t exp_val);
        int waited;
        @(posedge clock);
        #2;
        cyc = 1'b1;
        stb = 1'b1;
        we = write;
        adr = a;
        dat_w = d;
        exp_data = exp_val;
        waited = 0;
        do
        begin
            @(posedge clock);
            #2;
            waited++;
        end
        while (!ack && waited < ACK_TIMEOUT);
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        if (!ack)
        begin
            $display("no ack within %0d cycles for access to adr %0d", ACK_TIMEOUT, a);
            end_run(1'b1);
        end
    endtask

    task automatic bus_write(input wb_addr_t a, input wb_data_t d);
        bus_cycle(1'b1, a, d, 8'h00);
    endtask

    task automatic bus_read(input wb_addr_t a, input wb_data_t exp_val);
        bus_cycle(1'b0, a, 8'h00, exp_val);
    endtask

    // random word with n_err distinct nonzero errors; stray adds ignored writes.
    // cancel_s1 picks the second error so that the two cancel in S1.
    task automatic run_word(input int n_err, input logic stray, input logic cancel_s1);
        msg_t       msg;
        word_t      word;
        word_t      fixed;
        logic       corr;
        logic       unc;
        int         p1;
        int         p2;
        gf_symbol_t e1;
        gf_symbol_t e2;
        for (int i = 0; i < CODE_LEN - 2; i++)
            msg[5*i +: 5] = gf_symbol_t'(rand_below(32));
        word = encode_word(msg);
        p1 = rand_below(CODE_LEN);
        p2 = (p1 + 1 + rand_below(CODE_LEN - 1)) % CODE_LEN;
        e1 = '0;
        if (n_err >= 1)
        begin
            e1 = gf_symbol_t'(1 + rand_below(31));
            word[5*p1 +: 5] = word[5*p1 +: 5] ^ e1;
        end
        if (n_err >= 2)
        begin
            // e2*a^p2 == e1*a^p1 leaves S1 zero and S2 nonzero.
            if (cancel_s1)
                e2 = ref_mul(e1, ref_pow(p1 + CODE_LEN - p2));
            else
                e2 = gf_symbol_t'(1 + rand_below(31));
            word[5*p2 +: 5] = word[5*p2 +: 5] ^ e2;
        end
        decode_ref(word, fixed, corr, unc);
        for (int j = CODE_LEN - 1; j >= 0; j--)
        begin
            bus_write(2'd0, {3'b000, word[5*j +: 5]});
            if (stray && j == 15)
                bus_write(2'd2, 8'h1f);
        end
        bus_read(2'd1, 8'h01);
        // symbol write while delivering.
        if (stray)
            bus_write(2'd0, 8'h15);
        for (int j = CODE_LEN - 1; j >= 0; j--)
            bus_read(2'd0, {3'b000, fixed[5*j +: 5]});
        bus_read(2'd1, {5'b00000, unc, corr, 1'b0});
    endtask

    initial
    begin
        clock = 1'b0;
        rst_n = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_w = '0;
        exp_data = '0;
        rand_state = 32'd23808;
        build_tables();
        repeat (10) @(posedge clock);
        #2;
        rst_n = 1'b1;

        // idle status and data port after reset.
        bus_read(2'd1, 8'h00);
        bus_read(2'd0, 8'h00);

        run_word(0, 1'b0, 1'b0);
        run_word(1, 1'b0, 1'b0);
        run_word(2, 1'b0, 1'b0);

        // two errors with S1 zero, flagged uncorrectable.
        run_word(2, 1'b0, 1'b1);

        // data read while collecting, then a word with stray writes.
        bus_read(2'd0, 8'h00);
        run_word(1, 1'b1, 1'b0);

        for (int k = 0; k < 10; k++)
            run_word(rand_below(3), 1'b0, 1'b0);

        repeat (4) @(posedge clock);
        end_run(1'b0);
    end

endmodule

`default_nettype wire

// File: compile.f
source/rs_pkg.sv
source/fifo_register.sv
source/syndrome_calc.sv
source/chien_corrector.sv
source/rs_wb_slave.sv
source/rs_decoder_top.sv
testbench/rs_checker.sv
testbench/tb_rs_decoder.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the RS decoder testbench with Verilator, runs it and scans sim.log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_rs_decoder \
    -o tb_rs_decoder \
    && ./obj_dir/tb_rs_decoder > sim.log 2>&1 \
    || { echo "FAIL: build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
